//--- verilog/dma_csr_defs.svh
// --------------------------------------------------------------------------
// Register map of the DMA control and status block: word indices, bit
// positions inside the control and length words, and identification values.
// Included by every RTL and bench file that names a register or a field.
// --------------------------------------------------------------------------
`ifndef DMA_CSR_DEFS_SVH
`define DMA_CSR_DEFS_SVH

// Implemented words, higher indices complete with pslverr
`define DMA_CSR_NUM_REGS    11

// Word indices
`define DMA_REG_ID          4'd0
`define DMA_REG_CTRL        4'd1
`define DMA_REG_WR_ADDR     4'd2
`define DMA_REG_WR_LEN      4'd3
`define DMA_REG_WR_COUNT    4'd4
`define DMA_REG_RD_ADDR     4'd5
`define DMA_REG_RD_LEN      4'd6
`define DMA_REG_RD_COUNT    4'd7
`define DMA_REG_WR_PERF     4'd8    // Read only
`define DMA_REG_RD_PERF     4'd9    // Read only
`define DMA_REG_CPLD_SIZE   4'd10   // Read only

// Identification word contents
`define DMA_VERSION         8'h16
`define DMA_IF_TYPE         4'h2
`define DMA_FPGA_FAMILY     8'h14
`define DMA_ID_INIT_RST     0       // Initiator reset, the only writable bit

// Control word
`define DMA_CTRL_WR_START   0
`define DMA_CTRL_WR_INT_DIS 7
`define DMA_CTRL_WR_DONE    8       // Status from the write engine
`define DMA_CTRL_RD_START   16
`define DMA_CTRL_RD_INT_DIS 23
`define DMA_CTRL_RD_DONE    24      // Sticky completion flag

// Length word
`define DMA_LEN_LEN_MSB     15
`define DMA_LEN_LEN_LSB     0
`define DMA_LEN_TC_MSB      18
`define DMA_LEN_TC_LSB      16
`define DMA_LEN_64B         19
`define DMA_LEN_UPA_MSB     31
`define DMA_LEN_UPA_LSB     24

`endif

//--- verilog/dma_csr_pkg.sv
// --------------------------------------------------------------------------
// Shared types of the DMA CSR block: meaningful vector widths, the APB
// request and response, the internal register access and the descriptors.
// --------------------------------------------------------------------------
package dma_csr_pkg;

    typedef logic [31:0] csr_word_t;
    typedef logic [3:0]  csr_index_t;
    typedef logic [15:0] dw_len_t;      // Transfer length in dwords
    typedef logic [2:0]  tlp_tc_t;
    typedef logic [20:0] cpld_size_t;   // Up to 2M dwords

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        csr_word_t paddr;
        csr_word_t pwdata;
    } apb_req_t;

    typedef struct packed {
        csr_word_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    // One register access from the APB port
    typedef struct packed {
        logic       valid;
        logic       write;
        csr_index_t index;
        csr_word_t  wdata;
    } csr_access_t;

    typedef struct packed {
        csr_word_t  addr;
        dw_len_t    len;
        tlp_tc_t    tc;
        logic       en_64b;
        logic [7:0] up_addr;
        csr_word_t  count;     // Packets per run
        logic       start;
        logic       int_dis;
    } dma_desc_t;

    typedef struct packed {
        dma_desc_t wr;
        dma_desc_t rd;
    } dma_ctrl_t;

    typedef struct packed {
        csr_word_t  wr_cycles;
        csr_word_t  rd_cycles;
        cpld_size_t cpld_size;
        logic       rd_done;
    } perf_status_t;

endpackage

//--- verilog/apb_csr_port.sv
// --------------------------------------------------------------------------
// APB slave front end of the CSR block. Every transfer gets one wait state.
// The setup cycle is turned into a one-cycle register access, and the
// registered read word comes back with pready in the second access cycle.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "dma_csr_defs.svh"

module apb_csr_port (
    input  logic                     clk,
    input  logic                     rst_n,
    input  dma_csr_pkg::apb_req_t    apb_req_i,
    output dma_csr_pkg::apb_rsp_t    apb_rsp_o,
    output dma_csr_pkg::csr_access_t access_o,
    input  dma_csr_pkg::csr_word_t   rdata_i
);

    dma_csr_pkg::csr_index_t index_w;
    logic                    setup_w;
    logic                    first_acc_w;
    logic                    in_range_w;

    logic                    acc_valid_q;
    logic                    acc_write_q;
    dma_csr_pkg::csr_index_t acc_index_q;
    dma_csr_pkg::csr_word_t  acc_wdata_q;
    logic                    pready_q;
    logic                    slverr_q;

    assign index_w     = apb_req_i.paddr[5:2];  // Byte address to word index
    assign setup_w     = apb_req_i.psel & ~apb_req_i.penable;
    assign first_acc_w = apb_req_i.psel & apb_req_i.penable & ~pready_q;
    assign in_range_w  = index_w < dma_csr_pkg::csr_index_t'(`DMA_CSR_NUM_REGS);

    // ------------------------------------------------------------------------
    // Phase tracking
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc_valid_q <= 1'b0;
            pready_q    <= 1'b0;
            slverr_q    <= 1'b0;
        end else begin
            acc_valid_q <= setup_w & in_range_w;  // No strobe for bad indices
            pready_q    <= first_acc_w;           // Wait state, then ready
            if (setup_w) begin
                slverr_q <= ~in_range_w;
            end
        end
    end

    // Access payload, captured in the setup cycle
    always_ff @(posedge clk) begin
        if (setup_w) begin
            acc_write_q <= apb_req_i.pwrite;
            acc_index_q <= index_w;
            acc_wdata_q <= apb_req_i.pwdata;
        end
    end

    assign access_o = '{
        valid: acc_valid_q,
        write: acc_write_q,
        index: acc_index_q,
        wdata: acc_wdata_q
    };

    // ------------------------------------------------------------------------
    // Response
    // ------------------------------------------------------------------------
    assign apb_rsp_o.prdata  = (pready_q && !slverr_q) ? rdata_i : '0;
    assign apb_rsp_o.pready  = pready_q;
    assign apb_rsp_o.pslverr = pready_q & slverr_q;

endmodule

//--- verilog/dma_csr_regs.sv
// --------------------------------------------------------------------------
// Register storage of the DMA CSR block. Accesses from the APB port load
// the read word on the strobe edge and commit writes one edge later, which
// is the edge that completes the APB transfer.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "dma_csr_defs.svh"

module dma_csr_regs (
    input  logic                      clk,
    input  logic                      rst_n,
    input  dma_csr_pkg::csr_access_t  access_i,
    output dma_csr_pkg::csr_word_t    rdata_o,
    input  logic                      mwr_done_i,
    input  dma_csr_pkg::perf_status_t perf_i,
    output dma_csr_pkg::dma_ctrl_t    dma_ctrl_o,
    output logic                      init_rst_o
);

    dma_csr_pkg::dma_ctrl_t  ctrl_q;
    logic                    init_rst_q;
    logic                    wr_pend_q;
    dma_csr_pkg::csr_index_t wr_index_q;
    dma_csr_pkg::csr_word_t  wr_data_q;
    dma_csr_pkg::csr_word_t  rdata_q;
    dma_csr_pkg::csr_word_t  id_word_w;
    dma_csr_pkg::csr_word_t  ctrl_word_w;
    dma_csr_pkg::csr_word_t  rdata_w;

    // Pack the length word of a descriptor
    function automatic dma_csr_pkg::csr_word_t len_word(
        input dma_csr_pkg::dma_desc_t d
    );
        dma_csr_pkg::csr_word_t w;
        w = '0;
        w[`DMA_LEN_LEN_MSB:`DMA_LEN_LEN_LSB] = d.len;
        w[`DMA_LEN_TC_MSB:`DMA_LEN_TC_LSB]   = d.tc;
        w[`DMA_LEN_64B]                      = d.en_64b;
        w[`DMA_LEN_UPA_MSB:`DMA_LEN_UPA_LSB] = d.up_addr;
        return w;
    endfunction

    // Load the length word fields, other fields untouched
    function automatic dma_csr_pkg::dma_desc_t set_len(
        input dma_csr_pkg::dma_desc_t d,
        input dma_csr_pkg::csr_word_t w
    );
        dma_csr_pkg::dma_desc_t r;
        r         = d;
        r.len     = w[`DMA_LEN_LEN_MSB:`DMA_LEN_LEN_LSB];
        r.tc      = w[`DMA_LEN_TC_MSB:`DMA_LEN_TC_LSB];
        r.en_64b  = w[`DMA_LEN_64B];
        r.up_addr = w[`DMA_LEN_UPA_MSB:`DMA_LEN_UPA_LSB];
        return r;
    endfunction

    // ------------------------------------------------------------------------
    // Write path
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_pend_q <= 1'b0;
        end else begin
            wr_pend_q <= access_i.valid & access_i.write;
        end
    end

    always_ff @(posedge clk) begin
        if (access_i.valid) begin
            wr_index_q <= access_i.index;
            wr_data_q  <= access_i.wdata;
            rdata_q    <= rdata_w;         // Word as it was before the write
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl_q     <= '0;
            init_rst_q <= 1'b0;
        end else begin
            if (wr_pend_q) begin
                case (wr_index_q)
                    `DMA_REG_ID:       init_rst_q <= wr_data_q[`DMA_ID_INIT_RST];
                    `DMA_REG_CTRL: begin
                        ctrl_q.wr.start   <= wr_data_q[`DMA_CTRL_WR_START];
                        ctrl_q.wr.int_dis <= wr_data_q[`DMA_CTRL_WR_INT_DIS];
                        ctrl_q.rd.start   <= wr_data_q[`DMA_CTRL_RD_START];
                        ctrl_q.rd.int_dis <= wr_data_q[`DMA_CTRL_RD_INT_DIS];
                    end
                    `DMA_REG_WR_ADDR:  ctrl_q.wr.addr  <= wr_data_q;
                    `DMA_REG_WR_LEN:   ctrl_q.wr       <= set_len(ctrl_q.wr, wr_data_q);
                    `DMA_REG_WR_COUNT: ctrl_q.wr.count <= wr_data_q;
                    `DMA_REG_RD_ADDR:  ctrl_q.rd.addr  <= wr_data_q;
                    `DMA_REG_RD_LEN:   ctrl_q.rd       <= set_len(ctrl_q.rd, wr_data_q);
                    `DMA_REG_RD_COUNT: ctrl_q.rd.count <= wr_data_q;
                    default: ;                     // Status words ignore writes
                endcase
            end
            // Initiator reset holds both engines stopped
            if (init_rst_q) begin
                ctrl_q.wr.start <= 1'b0;
                ctrl_q.rd.start <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Read path
    // ------------------------------------------------------------------------
    assign id_word_w = {`DMA_FPGA_FAMILY, 4'h0, `DMA_IF_TYPE, `DMA_VERSION,
                        7'h0, init_rst_q};

    always_comb begin
        ctrl_word_w = '0;
        ctrl_word_w[`DMA_CTRL_WR_START]   = ctrl_q.wr.start;
        ctrl_word_w[`DMA_CTRL_WR_INT_DIS] = ctrl_q.wr.int_dis;
        ctrl_word_w[`DMA_CTRL_WR_DONE]    = mwr_done_i;
        ctrl_word_w[`DMA_CTRL_RD_START]   = ctrl_q.rd.start;
        ctrl_word_w[`DMA_CTRL_RD_INT_DIS] = ctrl_q.rd.int_dis;
        ctrl_word_w[`DMA_CTRL_RD_DONE]    = perf_i.rd_done;
    end

    always_comb begin
        case (access_i.index)
            `DMA_REG_ID:        rdata_w = id_word_w;
            `DMA_REG_CTRL:      rdata_w = ctrl_word_w;
            `DMA_REG_WR_ADDR:   rdata_w = ctrl_q.wr.addr;
            `DMA_REG_WR_LEN:    rdata_w = len_word(ctrl_q.wr);
            `DMA_REG_WR_COUNT:  rdata_w = ctrl_q.wr.count;
            `DMA_REG_RD_ADDR:   rdata_w = ctrl_q.rd.addr;
            `DMA_REG_RD_LEN:    rdata_w = len_word(ctrl_q.rd);
            `DMA_REG_RD_COUNT:  rdata_w = ctrl_q.rd.count;
            `DMA_REG_WR_PERF:   rdata_w = perf_i.wr_cycles;
            `DMA_REG_RD_PERF:   rdata_w = perf_i.rd_cycles;
            `DMA_REG_CPLD_SIZE: rdata_w = {11'h0, perf_i.cpld_size};
            default:            rdata_w = '0;
        endcase
    end

    assign rdata_o    = rdata_q;
    assign dma_ctrl_o = ctrl_q;
    assign init_rst_o = init_rst_q;

endmodule

//--- verilog/dma_perf_monitor.sv
// --------------------------------------------------------------------------
// Performance counters and read completion tracking. Each counter runs
// while its engine is started and not done. Read-done is set once the
// reported completion size equals read length times packet count.
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module dma_perf_monitor (
    input  logic                      clk,
    input  logic                      rst_n,
    input  dma_csr_pkg::dma_ctrl_t    dma_ctrl_i,
    input  logic                      init_rst_i,
    input  logic                      mwr_done_i,
    input  dma_csr_pkg::cpld_size_t   cpld_data_size_i,
    output dma_csr_pkg::perf_status_t perf_o,
    output logic                      mrd_done_o
);

    localparam int NUM_DIR = 2;          // Index 0 writes, index 1 reads

    logic [NUM_DIR-1:0]      run_w;
    dma_csr_pkg::csr_word_t  cycles_q [NUM_DIR];
    logic [47:0]             expect_full_w;
    dma_csr_pkg::cpld_size_t expect_q;
    dma_csr_pkg::cpld_size_t observed_q;
    logic                    match_q;
    logic                    rd_done_q;

    assign run_w[0] = dma_ctrl_i.wr.start & ~mwr_done_i;
    assign run_w[1] = dma_ctrl_i.rd.start & ~rd_done_q;

    // ------------------------------------------------------------------------
    // Cycle counters
    // ------------------------------------------------------------------------
    for (genvar d = 0; d < NUM_DIR; d++) begin : g_cnt
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                cycles_q[d] <= '0;
            end else if (init_rst_i) begin
                cycles_q[d] <= '0;
            end else if (run_w[d]) begin
                cycles_q[d] <= cycles_q[d] + 32'd1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Completion compare, three register stages
    // ------------------------------------------------------------------------
    assign expect_full_w = dma_ctrl_i.rd.len * dma_ctrl_i.rd.count;

    always_ff @(posedge clk) begin
        if (!rst_n || init_rst_i) begin
            expect_q   <= '0;
            observed_q <= '0;
            match_q    <= 1'b0;
        end else begin
            expect_q   <= expect_full_w[20:0];    // Truncated to 2M dwords
            observed_q <= cpld_data_size_i;
            match_q    <= (expect_q == observed_q);
        end
    end

    // Sticky until the next initiator reset
    always_ff @(posedge clk) begin
        if (!rst_n || init_rst_i) begin
            rd_done_q <= 1'b0;
        end else if (dma_ctrl_i.rd.start && match_q) begin
            rd_done_q <= 1'b1;
        end
    end

    assign perf_o = '{
        wr_cycles: cycles_q[0],
        rd_cycles: cycles_q[1],
        cpld_size: observed_q,
        rd_done:   rd_done_q
    };
    assign mrd_done_o = rd_done_q;

endmodule

//--- verilog/dma_csr_top.sv
// --------------------------------------------------------------------------
// Top level of the DMA CSR block. APB port, register file and performance
// monitor, with the descriptors and the initiator reset brought out to the
// DMA engines.
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module dma_csr_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  dma_csr_pkg::apb_req_t   apb_req_i,
    output dma_csr_pkg::apb_rsp_t   apb_rsp_o,
    input  logic                    mwr_done_i,
    input  dma_csr_pkg::cpld_size_t cpld_data_size_i,
    output dma_csr_pkg::dma_ctrl_t  dma_ctrl_o,
    output logic                    init_rst_o,
    output logic                    mrd_done_o
);

    dma_csr_pkg::csr_access_t  access_w;
    dma_csr_pkg::csr_word_t    rdata_w;
    dma_csr_pkg::perf_status_t perf_w;

    apb_csr_port u_port (
        .clk       (clk),
        .rst_n     (rst_n),
        .apb_req_i (apb_req_i),
        .apb_rsp_o (apb_rsp_o),
        .access_o  (access_w),
        .rdata_i   (rdata_w)
    );

    dma_csr_regs u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .access_i   (access_w),
        .rdata_o    (rdata_w),
        .mwr_done_i (mwr_done_i),
        .perf_i     (perf_w),
        .dma_ctrl_o (dma_ctrl_o),
        .init_rst_o (init_rst_o)
    );

    dma_perf_monitor u_perf (
        .clk              (clk),
        .rst_n            (rst_n),
        .dma_ctrl_i       (dma_ctrl_o),
        .init_rst_i       (init_rst_o),
        .mwr_done_i       (mwr_done_i),
        .cpld_data_size_i (cpld_data_size_i),
        .perf_o           (perf_w),
        .mrd_done_o       (mrd_done_o)
    );

endmodule

//--- bench/dma_csr_sva.sv
// --------------------------------------------------------------------------
// Protocol and initiator reset assertions for the DMA CSR block. Bound to
// the top level by the testbench.
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module dma_csr_sva (
    input logic                   clk,
    input logic                   rst_n,
    input dma_csr_pkg::apb_req_t  apb_req_i,
    input dma_csr_pkg::apb_rsp_t  apb_rsp_i,
    input dma_csr_pkg::dma_ctrl_t dma_ctrl_i,
    input logic                   init_rst_i
);

    // Master holds the request while the slave waits
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        apb_req_i.psel && apb_req_i.penable && !apb_rsp_i.pready
        |=> $stable(apb_req_i))
        else $error("APB request changed while the access waited for pready");

    // One wait state, so no ready in the first access cycle
    a_no_early_ready: assert property (@(posedge clk) disable iff (!rst_n)
        apb_req_i.psel && $rose(apb_req_i.penable) |-> !apb_rsp_i.pready)
        else $error("pready high in the first access cycle");

    a_init_stops: assert property (@(posedge clk) disable iff (!rst_n)
        init_rst_i |=> !(dma_ctrl_i.wr.start || dma_ctrl_i.rd.start))
        else $error("Start bit high in the cycle after initiator reset");

endmodule

//--- bench/dma_csr_tb.sv
// --------------------------------------------------------------------------
// Testbench of the DMA CSR block. APB transfers are driven on the falling
// edge, a register model predicts every read and a comparing process
// checks the completed reads. Five tests, then a summary.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "dma_csr_defs.svh"

module dma_csr_tb;

    typedef dma_csr_pkg::csr_word_t  word_t;
    typedef dma_csr_pkg::csr_index_t index_t;

    localparam int CLK_HALF   = 2;
    localparam int RST_CYCLES = 16;
    localparam int XFER_LIMIT = 8;     // Cycles allowed for pready
    localparam int MAX_CYCLES = 4000;  // Tests need under 1500 cycles

    localparam word_t CTRL_WMASK = (32'd1 << `DMA_CTRL_WR_START)
                                 | (32'd1 << `DMA_CTRL_WR_INT_DIS)
                                 | (32'd1 << `DMA_CTRL_RD_START)
                                 | (32'd1 << `DMA_CTRL_RD_INT_DIS);
    localparam word_t LEN_WMASK  = 32'hFF0F_FFFF;  // Upper address, 64b, TC, length

    logic                    clk;
    logic                    rst_n;
    dma_csr_pkg::apb_req_t   apb_req;
    dma_csr_pkg::apb_rsp_t   apb_rsp;
    logic                    mwr_done;
    dma_csr_pkg::cpld_size_t cpld_size;
    dma_csr_pkg::dma_ctrl_t  dma_ctrl;
    logic                    init_rst;
    logic                    mrd_done;

    word_t  model [16];
    logic   model_rd_done;
    logic   exp_pending;
    logic   exp_exact;
    logic   exp_err;
    index_t exp_index;
    word_t  exp_data;
    int     cmp_err_cnt = 0;
    int     chk_err_cnt = 0;
    int     test_fail_cnt;
    int     cycle_cnt;
    integer seed;

    dma_csr_top u_dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .apb_req_i        (apb_req),
        .apb_rsp_o        (apb_rsp),
        .mwr_done_i       (mwr_done),
        .cpld_data_size_i (cpld_size),
        .dma_ctrl_o       (dma_ctrl),
        .init_rst_o       (init_rst),
        .mrd_done_o       (mrd_done)
    );

    bind dma_csr_top dma_csr_sva u_sva (
        .clk        (clk),
        .rst_n      (rst_n),
        .apb_req_i  (apb_req_i),
        .apb_rsp_i  (apb_rsp_o),
        .dma_ctrl_i (dma_ctrl_o),
        .init_rst_i (init_rst_o)
    );

    always #CLK_HALF clk = ~clk;

    // ------------------------------------------------------------------------
    // Register model
    // ------------------------------------------------------------------------
    function automatic word_t ref_read(input index_t idx);
        word_t w;
        w = '0;
        case (idx)
            `DMA_REG_ID: begin
                w = (32'(`DMA_FPGA_FAMILY) << 24) | (32'(`DMA_IF_TYPE) << 16)
                  | (32'(`DMA_VERSION) << 8);
                w[`DMA_ID_INIT_RST] = model[`DMA_REG_ID][`DMA_ID_INIT_RST];
            end
            `DMA_REG_CTRL: begin
                w = model[`DMA_REG_CTRL] & CTRL_WMASK;
                w[`DMA_CTRL_WR_DONE] = mwr_done;
                w[`DMA_CTRL_RD_DONE] = model_rd_done;
            end
            `DMA_REG_WR_LEN, `DMA_REG_RD_LEN: w = model[idx] & LEN_WMASK;
            default: if (int'(idx) < `DMA_CSR_NUM_REGS) w = model[idx];
        endcase
        return w;
    endfunction

    function automatic void model_write(input index_t idx, input word_t wdata);
        if (int'(idx) <= int'(`DMA_REG_RD_COUNT)) begin
            model[idx] = wdata;
        end
        // Initiator reset stops both engines
        if (model[`DMA_REG_ID][`DMA_ID_INIT_RST]) begin
            model[`DMA_REG_CTRL][`DMA_CTRL_WR_START] = 1'b0;
            model[`DMA_REG_CTRL][`DMA_CTRL_RD_START] = 1'b0;
            model_rd_done = 1'b0;
        end
    endfunction

    function automatic logic desc_matches(input dma_csr_pkg::dma_desc_t d, input int base);
        word_t lw;
        lw = model[base + 1];
        return d.addr == model[base] && d.count == model[base + 2]
            && d.len == lw[`DMA_LEN_LEN_MSB:`DMA_LEN_LEN_LSB]
            && d.tc == lw[`DMA_LEN_TC_MSB:`DMA_LEN_TC_LSB]
            && d.en_64b == lw[`DMA_LEN_64B]
            && d.up_addr == lw[`DMA_LEN_UPA_MSB:`DMA_LEN_UPA_LSB];
    endfunction

    // ------------------------------------------------------------------------
    // APB driver, called on a falling edge
    // ------------------------------------------------------------------------
    task automatic apb_xfer(input logic write, input index_t idx, input word_t wdata,
                            input logic exact, output word_t rdata);
        int wait_cnt;
        exp_index   = idx;
        exp_data    = ref_read(idx);
        exp_err     = int'(idx) >= `DMA_CSR_NUM_REGS;
        exp_exact   = exact & ~write;
        exp_pending = 1'b1;
        apb_req     = '{psel: 1'b1, penable: 1'b0, pwrite: write,
                        paddr: {26'h0, idx, 2'b00}, pwdata: wdata};
        @(negedge clk);
        apb_req.penable = 1'b1;
        wait_cnt = 0;
        do begin
            @(negedge clk);
            wait_cnt++;
        end while (!apb_rsp.pready && wait_cnt < XFER_LIMIT);
        if (!apb_rsp.pready) begin
            $display("Timeout: no pready on word %0d within %0d cycles", idx, XFER_LIMIT);
            $display("tests failed");
            $finish;
        end
        rdata = apb_rsp.prdata;
        @(negedge clk);                // Transfer completed on the last edge
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
        exp_pending     = 1'b0;
    endtask

    task automatic apb_write(input index_t idx, input word_t wdata);
        word_t ignored;
        apb_xfer(1'b1, idx, wdata, 1'b0, ignored);
        model_write(idx, wdata);
    endtask

    task automatic apb_read(input index_t idx, input logic exact, output word_t rdata);
        apb_xfer(1'b0, idx, '0, exact, rdata);
    endtask

    task automatic check_true(input logic ok, input string msg);
        assert (ok) else begin
            $display("Fail at %0t: %s", $time, msg);
            chk_err_cnt++;
        end
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        int errs;
        errs = cmp_err_cnt + chk_err_cnt - errs_before;
        if (errs == 0) begin
            $display("Test %0d %s: ok", num, name);
        end else begin
            $display("Test %0d %s: %0d errors", num, name, errs);
            test_fail_cnt++;
        end
    endtask

    // Checks every completed transfer against the model
    always @(negedge clk) begin
        if (exp_pending && apb_req.psel && apb_req.penable && apb_rsp.pready) begin
            assert (apb_rsp.pslverr == exp_err) else begin
                $display("Fail at %0t: word %0d pslverr %b, expected %b",
                         $time, exp_index, apb_rsp.pslverr, exp_err);
                cmp_err_cnt++;
            end
            if (exp_exact) begin
                assert (apb_rsp.prdata == exp_data) else begin
                    $display("Fail at %0t: word %0d read %h, expected %h",
                             $time, exp_index, apb_rsp.prdata, exp_data);
                    cmp_err_cnt++;
                end
            end
        end
    end

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: run exceeded %0d cycles", MAX_CYCLES);
        $display("tests failed");
        $finish;
    end

    // ------------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------------
    initial begin : main
        word_t                   rdata;
        word_t                   rdata2;
        logic [63:0]             prod;
        dma_csr_pkg::cpld_size_t expect_size;
        int                      wait_cnt;
        int                      errs_before;

        clk           = 1'b0;
        rst_n         = 1'b0;
        apb_req       = '0;
        mwr_done      = 1'b0;
        cpld_size     = '0;
        seed          = 70520;
        model_rd_done = 1'b0;
        exp_pending   = 1'b0;
        test_fail_cnt = 0;
        for (int i = 0; i < 16; i++) model[i] = '0;
        repeat (RST_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        errs_before = 0;
        for (int i = 0; i < `DMA_CSR_NUM_REGS; i++) apb_read(index_t'(i), 1'b1, rdata);
        report_test(1, "reset values", errs_before);

        errs_before = cmp_err_cnt + chk_err_cnt;
        for (int i = 2; i <= 7; i++) apb_write(index_t'(i), $random(seed));
        for (int i = 2; i <= 7; i++) apb_read(index_t'(i), 1'b1, rdata);
        check_true(desc_matches(dma_ctrl.wr, 2), "write descriptor differs on dma_ctrl_o");
        check_true(desc_matches(dma_ctrl.rd, 5), "read descriptor differs on dma_ctrl_o");
        report_test(2, "descriptor readback", errs_before);

        errs_before = cmp_err_cnt + chk_err_cnt;
        for (int i = 11; i < 16; i++) begin
            apb_write(index_t'(i), $random(seed));
            apb_read(index_t'(i), 1'b1, rdata);
        end
        for (int i = 0; i < `DMA_CSR_NUM_REGS; i++) apb_read(index_t'(i), 1'b1, rdata);
        report_test(3, "out of range words", errs_before);

        errs_before = cmp_err_cnt + chk_err_cnt;
        apb_write(`DMA_REG_CTRL, CTRL_WMASK);    // Both engines on, interrupts off
        check_true(dma_ctrl.wr.start && dma_ctrl.rd.start
                   && dma_ctrl.wr.int_dis && dma_ctrl.rd.int_dis,
                   "control bits missing on dma_ctrl_o");
        apb_read(`DMA_REG_WR_PERF, 1'b0, rdata);
        repeat (5) @(negedge clk);
        apb_read(`DMA_REG_WR_PERF, 1'b0, rdata2);
        check_true(rdata != 0, "write counter zero while write start is set");
        check_true(rdata2 > rdata, "write counter did not grow");
        mwr_done = 1'b1;
        repeat (2) @(negedge clk);
        apb_read(`DMA_REG_WR_PERF, 1'b0, rdata);
        apb_read(`DMA_REG_WR_PERF, 1'b0, rdata2);
        check_true(rdata == rdata2, "write counter moved after write done");
        apb_write(`DMA_REG_ID, 32'd1 << `DMA_ID_INIT_RST);
        apb_read(`DMA_REG_WR_PERF, 1'b1, rdata);
        apb_read(`DMA_REG_CTRL, 1'b1, rdata);
        check_true(init_rst && !dma_ctrl.wr.start && !dma_ctrl.rd.start,
                   "initiator reset left a start bit set");
        apb_write(`DMA_REG_ID, 32'd0);
        mwr_done = 1'b0;
        report_test(4, "write counter and initiator reset", errs_before);

        errs_before = cmp_err_cnt + chk_err_cnt;
        apb_write(`DMA_REG_RD_LEN, $random(seed));
        apb_write(`DMA_REG_RD_COUNT, $random(seed));
        prod = {48'h0, model[`DMA_REG_RD_LEN][15:0]} * {32'h0, model[`DMA_REG_RD_COUNT]};
        expect_size = prod[20:0];          // Product truncated to 21 bits
        cpld_size = expect_size + 21'd1;
        model[`DMA_REG_CPLD_SIZE] = {11'h0, cpld_size};
        apb_write(`DMA_REG_CTRL, 32'd1 << `DMA_CTRL_RD_START);
        repeat (10) @(negedge clk);
        check_true(!mrd_done, "read done set on a size mismatch");
        apb_read(`DMA_REG_CTRL, 1'b1, rdata);
        apb_read(`DMA_REG_CPLD_SIZE, 1'b1, rdata);
        cpld_size = expect_size;
        model[`DMA_REG_CPLD_SIZE] = {11'h0, cpld_size};
        wait_cnt = 0;
        while (!mrd_done && wait_cnt < 8) begin
            @(negedge clk);
            wait_cnt++;
        end
        check_true(mrd_done, "read done not set within 8 cycles of a size match");
        model_rd_done = 1'b1;
        apb_read(`DMA_REG_CTRL, 1'b1, rdata);
        apb_read(`DMA_REG_CPLD_SIZE, 1'b1, rdata);
        report_test(5, "completion tracking", errs_before);

        $display("Summary: 5 tests run, %0d with errors, %0d check errors",
                 test_fail_cnt, cmp_err_cnt + chk_err_cnt);
        if (cmp_err_cnt + chk_err_cnt == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+verilog
verilog/dma_csr_pkg.sv
verilog/apb_csr_port.sv
verilog/dma_csr_regs.sv
verilog/dma_perf_monitor.sv
verilog/dma_csr_top.sv
bench/dma_csr_sva.sv
bench/dma_csr_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the DMA CSR testbench with Verilator, run it into a log file and
# decide the result from the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=dma_csr_sim

verilator --binary --timing --assert --top-module dma_csr_tb -f project.f -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build exited with status $status"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^all tests passed$" "$LOG"; then
    echo "Result: PASS"
    exit 0
fi
echo "Result: FAIL, see $LOG"
exit 1
